// ==== ctr_pkg.sv ====
package ctr_pkg;

  // bank size
  localparam int COUNTER_NUM = 4;

  // apb data, target and count width
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;

  // channel windows start here, one window per channel
  localparam int CHAN_BASE   = 'h40;
  localparam int CHAN_STRIDE = 'h10;
  // low address bits that select a register inside a window
  localparam int CHAN_OFS_W  = $clog2(CHAN_STRIDE);

  // bit positions, shared by global and channel command registers
  localparam int CMD_START_BIT = 0;
  localparam int CMD_STOP_BIT  = 1;
  localparam int CMD_CLEAR_BIT = 2;

  // global register map, full byte address
  typedef enum logic [ADDR_W-1:0] {
    REG_GLOBAL_CMD  = 'h00,
    REG_ENABLE      = 'h04,
    REG_INTR_STATUS = 'h08,
    REG_INTR_SET    = 'h0C,
    REG_INTR_MASK   = 'h10,
    REG_MASK_SET    = 'h14,
    REG_MASK_CLR    = 'h18
  } reg_addr_e;

  // per-channel registers, offset inside the channel window
  // kept apart from the global map since offset 0 is used by both
  typedef enum logic [CHAN_OFS_W-1:0] {
    REG_CH_CMD    = 'h0,
    REG_CH_TARGET = 'h4,
    REG_CH_COUNT  = 'h8
  } ch_reg_e;

  // channel run state
  typedef enum logic {
    CH_STOPPED = 1'b0,
    CH_RUNNING = 1'b1
  } chan_state_e;

endpackage

// ==== ctr_chan_if.sv ====
`timescale 1ns/1ns

interface ctr_chan_if;
  import ctr_pkg::*;

  // one-cycle command strobes from the register block
  logic              start;
  logic              stop;
  logic              clear;
  // channel enable level
  logic              enable;
  // wrap value
  logic [DATA_W-1:0] target;
  // live count, sampled by reads
  logic [DATA_W-1:0] count;
  // one-cycle pulse on wrap
  logic              match;

  // register side
  modport regs (
    output start,
    output stop,
    output clear,
    output enable,
    output target,
    input  count
  );

  // counter side
  modport chan (
    input  start,
    input  stop,
    input  clear,
    input  enable,
    input  target,
    output count,
    output match
  );

endinterface

// ==== ctr_apb_regs.sv ====
`timescale 1ns/1ns

module ctr_apb_regs (
  input  logic                             i_pclk,
  input  logic                             i_prst_n,
  // apb slave
  input  logic [ctr_pkg::ADDR_W-1:0]       i_paddr,
  input  logic [ctr_pkg::DATA_W-1:0]       i_pwdata,
  input  logic                             i_pwrite,
  input  logic                             i_psel,
  input  logic                             i_penable,
  output logic [ctr_pkg::DATA_W-1:0]       o_prdata,
  output logic [ctr_pkg::COUNTER_NUM-1:0]  o_enable,
  // channel side
  ctr_chan_if.regs                         chan_if [ctr_pkg::COUNTER_NUM],
  // interrupt controller writes
  output logic [ctr_pkg::COUNTER_NUM-1:0]  o_intr_wdata,
  output logic                             o_intr_clr_wr,
  output logic                             o_intr_set_wr,
  output logic                             o_mask_set_wr,
  output logic                             o_mask_clr_wr,
  // interrupt controller readback
  input  logic [ctr_pkg::COUNTER_NUM-1:0]  i_intr_status,
  input  logic [ctr_pkg::COUNTER_NUM-1:0]  i_intr_mask
);
  import ctr_pkg::*;

  // setup-phase access qualifiers
  logic                   wr_en;
  logic                   rd_en;
  // global register write decode
  logic                   glb_cmd_wr;
  logic                   enable_wr;
  // channel window hit and offset inside the window
  logic [COUNTER_NUM-1:0] ch_hit;
  logic [CHAN_OFS_W-1:0]  ch_ofs;
  // per-channel values gathered for the read mux
  logic [DATA_W-1:0]      tgt_w   [COUNTER_NUM];
  logic [DATA_W-1:0]      count_w [COUNTER_NUM];
  logic [DATA_W-1:0]      rd_data;

  // decode in setup phase only, access phase is ignored
  assign wr_en  = i_psel & i_pwrite & ~i_penable;
  assign rd_en  = i_psel & ~i_pwrite & ~i_penable;
  assign ch_ofs = i_paddr[CHAN_OFS_W-1:0];

  // global writes
  always_comb begin
    glb_cmd_wr    = 1'b0;
    enable_wr     = 1'b0;
    o_intr_clr_wr = 1'b0;
    o_intr_set_wr = 1'b0;
    o_mask_set_wr = 1'b0;
    o_mask_clr_wr = 1'b0;
    if (wr_en) begin
      case (i_paddr)
        REG_GLOBAL_CMD:  glb_cmd_wr    = 1'b1;
        REG_ENABLE:      enable_wr     = 1'b1;
        // status register is write-one-to-clear
        REG_INTR_STATUS: o_intr_clr_wr = 1'b1;
        REG_INTR_SET:    o_intr_set_wr = 1'b1;
        REG_MASK_SET:    o_mask_set_wr = 1'b1;
        REG_MASK_CLR:    o_mask_clr_wr = 1'b1;
        // mask itself is read-only, unmapped writes dropped
        default: ;
      endcase
    end
  end

  // interrupt writes act at the setup edge, bits line up with channels
  assign o_intr_wdata = i_pwdata[COUNTER_NUM-1:0];

  // channel enables
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_enable <= '0;
    end else if (enable_wr) begin
      o_enable <= i_pwdata[COUNTER_NUM-1:0];
    end
  end

  for (genvar i = 0; i < COUNTER_NUM; i++) begin : g_chan
    logic [ADDR_W-1:0] win_base;
    logic              ch_cmd_wr;
    logic              ch_tgt_wr;
    logic              cmd_wr;
    logic              start_q;
    logic              stop_q;
    logic              clear_q;
    logic [DATA_W-1:0] target_q;

    // window base of this channel
    assign win_base  = ADDR_W'(CHAN_BASE + i * CHAN_STRIDE);
    assign ch_hit[i] = (i_paddr[ADDR_W-1:CHAN_OFS_W] == win_base[ADDR_W-1:CHAN_OFS_W]);
    assign ch_cmd_wr = wr_en & ch_hit[i] & (ch_ofs == REG_CH_CMD);
    assign ch_tgt_wr = wr_en & ch_hit[i] & (ch_ofs == REG_CH_TARGET);
    // global command hits every channel
    assign cmd_wr    = glb_cmd_wr | ch_cmd_wr;

    // strobes high for exactly the cycle after the write edge
    always_ff @(posedge i_pclk or negedge i_prst_n) begin
      if (!i_prst_n) begin
        start_q <= 1'b0;
        stop_q  <= 1'b0;
        clear_q <= 1'b0;
      end else begin
        start_q <= cmd_wr & i_pwdata[CMD_START_BIT];
        stop_q  <= cmd_wr & i_pwdata[CMD_STOP_BIT];
        clear_q <= cmd_wr & i_pwdata[CMD_CLEAR_BIT];
      end
    end

    // target comes up all ones, so an idle channel never wraps early
    always_ff @(posedge i_pclk or negedge i_prst_n) begin
      if (!i_prst_n) begin
        target_q <= '1;
      end else if (ch_tgt_wr) begin
        target_q <= i_pwdata;
      end
    end

    assign chan_if[i].start  = start_q;
    assign chan_if[i].stop   = stop_q;
    assign chan_if[i].clear  = clear_q;
    assign chan_if[i].enable = o_enable[i];
    assign chan_if[i].target = target_q;

    assign tgt_w[i]   = target_q;
    assign count_w[i] = chan_if[i].count;
  end

  // read mux, write-only and unmapped locations read zero
  always_comb begin
    rd_data = '0;
    case (i_paddr)
      REG_ENABLE:      rd_data = DATA_W'(o_enable);
      REG_INTR_STATUS: rd_data = DATA_W'(i_intr_status);
      REG_INTR_MASK:   rd_data = DATA_W'(i_intr_mask);
      default: ;
    endcase
    // windows are disjoint from the global map
    for (int j = 0; j < COUNTER_NUM; j++) begin
      if (ch_hit[j]) begin
        case (ch_ofs)
          REG_CH_TARGET: rd_data = tgt_w[j];
          REG_CH_COUNT:  rd_data = count_w[j];
          default: ;
        endcase
      end
    end
  end

  // read data captured at the setup edge, held until the next read
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_prdata <= '0;
    end else if (rd_en) begin
      o_prdata <= rd_data;
    end
  end

endmodule

// ==== ctr_channel.sv ====
`timescale 1ns/1ns

module ctr_channel (
  input  logic     i_pclk,
  input  logic     i_prst_n,
  ctr_chan_if.chan chan_if
);
  import ctr_pkg::*;

  chan_state_e       state_q;
  logic [DATA_W-1:0] count_q;
  logic              match_q;
  // count moves this edge
  logic              advance;
  logic              at_target;

  // stop and clear both hold the count for this edge
  assign advance   = (state_q == CH_RUNNING) & chan_if.enable
                   & ~chan_if.stop & ~chan_if.clear;
  assign at_target = (count_q == chan_if.target);

  // run state
  // stop wins over start, clear masks start
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      state_q <= CH_STOPPED;
    end else if (chan_if.stop) begin
      state_q <= CH_STOPPED;
    end else if (chan_if.start && !chan_if.clear) begin
      state_q <= CH_RUNNING;
    end
  end

  // count register
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      count_q <= '0;
    end else if (chan_if.clear) begin
      // run state untouched
      count_q <= '0;
    end else if (advance) begin
      // wrap on equality, not overflow
      if (at_target) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // one-cycle match pulse following the wrap edge
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      match_q <= 1'b0;
    end else begin
      match_q <= advance & at_target;
    end
  end

  assign chan_if.count = count_q;
  assign chan_if.match = match_q;

endmodule

// ==== ctr_intr_ctrl.sv ====
`timescale 1ns/1ns

module ctr_intr_ctrl (
  input  logic                            i_pclk,
  input  logic                            i_prst_n,
  // one bit per channel match
  input  logic [ctr_pkg::COUNTER_NUM-1:0] i_intr_src,
  // register writes
  input  logic [ctr_pkg::COUNTER_NUM-1:0] i_intr_wdata,
  input  logic                            i_intr_clr_wr,
  input  logic                            i_intr_set_wr,
  input  logic                            i_mask_set_wr,
  input  logic                            i_mask_clr_wr,
  // readback
  output logic [ctr_pkg::COUNTER_NUM-1:0] o_intr_status,
  output logic [ctr_pkg::COUNTER_NUM-1:0] o_intr_mask,
  // level interrupt
  output logic                            o_int
);
  import ctr_pkg::*;

  // write data qualified by its strobe
  logic [COUNTER_NUM-1:0] stat_clr;
  logic [COUNTER_NUM-1:0] stat_set;
  logic [COUNTER_NUM-1:0] mask_set;
  logic [COUNTER_NUM-1:0] mask_clr;

  assign stat_clr = i_intr_clr_wr ? i_intr_wdata : '0;
  assign stat_set = i_intr_set_wr ? i_intr_wdata : '0;
  assign mask_set = i_mask_set_wr ? i_intr_wdata : '0;
  assign mask_clr = i_mask_clr_wr ? i_intr_wdata : '0;

  // sticky status
  // source and set are ORed last so a match beats a same-cycle clear
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_intr_status <= '0;
    end else begin
      o_intr_status <= (o_intr_status & ~stat_clr) | stat_set | i_intr_src;
    end
  end

  // mask, 1 = masked
  // everything masked out of reset
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_intr_mask <= '1;
    end else begin
      o_intr_mask <= (o_intr_mask | mask_set) & ~mask_clr;
    end
  end

  // level output, any pending unmasked bit
  assign o_int = |(o_intr_status & ~o_intr_mask);

endmodule

// ==== ctr_top.sv ====
`timescale 1ns/1ns

module ctr_top (
  input  logic                            i_pclk,
  input  logic                            i_prst_n,
  // apb slave
  input  logic [ctr_pkg::ADDR_W-1:0]      i_paddr,
  input  logic [ctr_pkg::DATA_W-1:0]      i_pwdata,
  input  logic                            i_pwrite,
  input  logic                            i_psel,
  input  logic                            i_penable,
  output logic [ctr_pkg::DATA_W-1:0]      o_prdata,
  // channel enables
  output logic [ctr_pkg::COUNTER_NUM-1:0] o_enable,
  // level interrupt
  output logic                            o_int
);
  import ctr_pkg::*;

  // match pulses into the interrupt controller
  logic [COUNTER_NUM-1:0] intr_src;
  // register block to interrupt controller
  logic [COUNTER_NUM-1:0] intr_wdata;
  logic                   intr_clr_wr;
  logic                   intr_set_wr;
  logic                   mask_set_wr;
  logic                   mask_clr_wr;
  // readback
  logic [COUNTER_NUM-1:0] intr_status;
  logic [COUNTER_NUM-1:0] intr_mask;

  // one bundle per channel
  ctr_chan_if chan_if [COUNTER_NUM] ();

  ctr_apb_regs u_regs (
    .i_pclk        (i_pclk),
    .i_prst_n      (i_prst_n),
    .i_paddr       (i_paddr),
    .i_pwdata      (i_pwdata),
    .i_pwrite      (i_pwrite),
    .i_psel        (i_psel),
    .i_penable     (i_penable),
    .o_prdata      (o_prdata),
    .o_enable      (o_enable),
    .chan_if       (chan_if),
    .o_intr_wdata  (intr_wdata),
    .o_intr_clr_wr (intr_clr_wr),
    .o_intr_set_wr (intr_set_wr),
    .o_mask_set_wr (mask_set_wr),
    .o_mask_clr_wr (mask_clr_wr),
    .i_intr_status (intr_status),
    .i_intr_mask   (intr_mask)
  );

  for (genvar i = 0; i < COUNTER_NUM; i++) begin : g_chan
    ctr_channel u_chan (
      .i_pclk   (i_pclk),
      .i_prst_n (i_prst_n),
      .chan_if  (chan_if[i])
    );
    // source bit i is channel i
    assign intr_src[i] = chan_if[i].match;
  end

  ctr_intr_ctrl u_intr (
    .i_pclk        (i_pclk),
    .i_prst_n      (i_prst_n),
    .i_intr_src    (intr_src),
    .i_intr_wdata  (intr_wdata),
    .i_intr_clr_wr (intr_clr_wr),
    .i_intr_set_wr (intr_set_wr),
    .i_mask_set_wr (mask_set_wr),
    .i_mask_clr_wr (mask_clr_wr),
    .o_intr_status (intr_status),
    .o_intr_mask   (intr_mask),
    .o_int         (o_int)
  );

endmodule

// ==== ctr_props.sv ====
`timescale 1ns/1ns

module ctr_props (
  input logic                            i_pclk,
  input logic                            i_prst_n,
  input logic                            i_psel,
  input logic                            i_penable,
  input logic                            i_pwrite,
  input logic [ctr_pkg::DATA_W-1:0]      i_prdata,
  input logic                            i_int,
  // match pulses and mask, one bit per channel
  input logic [ctr_pkg::COUNTER_NUM-1:0] i_match,
  input logic [ctr_pkg::COUNTER_NUM-1:0] i_mask,
  // channel 1 is the one that wraps on a small target
  input logic [ctr_pkg::DATA_W-1:0]      i_count1,
  input logic [ctr_pkg::DATA_W-1:0]      i_target1,
  input ctr_pkg::chan_state_e            i_state1
);
  import ctr_pkg::*;

  // setup phase of a read
  logic rd_setup;

  assign rd_setup = i_psel & ~i_pwrite & ~i_penable;

  // no channel holds match two cycles in a row
  match_pulse: assert property (@(posedge i_pclk) disable iff (!i_prst_n)
    (i_match & $past(i_match)) == '0)
    else $error("match pulse on a channel lasted more than one cycle");

  // wrap leaves the count at zero, channel still running
  wrap_bound: assert property (@(posedge i_pclk) disable iff (!i_prst_n)
    i_match[1] |-> (i_count1 == '0) && (i_state1 == CH_RUNNING))
    else $error("channel 1 count not zero at match");

  // one edge later still bounded
  wrap_next: assert property (@(posedge i_pclk) disable iff (!i_prst_n)
    i_match[1] |=> i_count1 <= i_target1)
    else $error("channel 1 count above target after match");

  // fully masked bank keeps the line low
  mask_quiet: assert property (@(posedge i_pclk) disable iff (!i_prst_n)
    (&i_mask) |-> !i_int)
    else $error("interrupt high with every source masked");

  // read data only moves after a setup-phase read
  prdata_hold: assert property (@(posedge i_pclk) disable iff (!i_prst_n)
    !rd_setup |=> $stable(i_prdata))
    else $error("read data changed without a read access");

endmodule

bind ctr_top ctr_props u_props (
  .i_pclk    (i_pclk),
  .i_prst_n  (i_prst_n),
  .i_psel    (i_psel),
  .i_penable (i_penable),
  .i_pwrite  (i_pwrite),
  .i_prdata  (o_prdata),
  .i_int     (o_int),
  .i_match   (intr_src),
  .i_mask    (intr_mask),
  .i_count1  (chan_if[1].count),
  .i_target1 (chan_if[1].target),
  .i_state1  (g_chan[1].u_chan.state_q)
);

// ==== tb_ctr_top.sv ====
`timescale 1ns/1ns

module tb_ctr_top;
  import ctr_pkg::*;

  logic                   pclk;
  logic                   prst_n;
  logic [ADDR_W-1:0]      paddr;
  logic [DATA_W-1:0]      pwdata;
  logic                   pwrite;
  logic                   psel;
  logic                   penable;
  logic [DATA_W-1:0]      prdata;
  logic [COUNTER_NUM-1:0] enable;
  logic                   intr;

  // stimulus table, one entry per step
  string                  step_name [$];
  string                  step_op   [$];
  logic [ADDR_W-1:0]      step_addr [$];
  logic [DATA_W-1:0]      step_data [$];
  logic [DATA_W-1:0]      step_exp  [$];

  integer                 seed;
  int                     cycles;
  int                     limit;
  // random target for channel 1
  logic [DATA_W-1:0]      tgt;
  logic [DATA_W-1:0]      rd_val;
  // previous read, for hold checks
  logic [DATA_W-1:0]      last_rd;

  ctr_top dut0 (
    .i_pclk    (pclk),
    .i_prst_n  (prst_n),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .i_pwrite  (pwrite),
    .i_psel    (psel),
    .i_penable (penable),
    .o_prdata  (prdata),
    .o_enable  (enable),
    .o_int     (intr)
  );

  initial begin
    pclk = 1'b0;
    forever #4 pclk = ~pclk;
  end

  // run length guard, limit set once the table is built
  always @(posedge pclk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: run went past %0d cycles without finishing", limit);
      $display("Errors found");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  // byte address of a register in a channel window
  function automatic logic [ADDR_W-1:0] ch_reg(input int ch, input ch_reg_e ofs);
    ch_reg = ADDR_W'(CHAN_BASE + ch * CHAN_STRIDE) + ADDR_W'(ofs);
  endfunction

  task automatic add_step(input string name, input string op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp);
    step_name.push_back(name);
    step_op.push_back(op);
    step_addr.push_back(addr);
    step_data.push_back(data);
    step_exp.push_back(exp);
  endtask

  task automatic check(input string name, input logic [DATA_W-1:0] exp,
                       input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
      $display("Errors found");
      $fatal(1, "value mismatch in step %s", name);
    end
  endtask

  // setup then access, bus idle again at the last falling edge
  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge pclk);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge pclk);
    penable = 1'b1;
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    @(negedge pclk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge pclk);
    penable = 1'b1;
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
    // read data registered at the setup edge and held since
    data    = prdata;
  endtask

  task automatic build_table();
    logic [DATA_W-1:0] start_cmd;
    logic [DATA_W-1:0] stop_cmd;
    logic [DATA_W-1:0] clear_cmd;
    logic [DATA_W-1:0] all_ch;
    start_cmd = DATA_W'(1) << CMD_START_BIT;
    stop_cmd  = DATA_W'(1) << CMD_STOP_BIT;
    clear_cmd = DATA_W'(1) << CMD_CLEAR_BIT;
    all_ch    = (DATA_W'(1) << COUNTER_NUM) - 1;
    // reset values
    add_step("reset_enable", "rd", REG_ENABLE, 0, 0);
    add_step("reset_status", "rd", REG_INTR_STATUS, 0, 0);
    add_step("reset_mask", "rd", REG_INTR_MASK, 0, all_ch);
    for (int ch = 0; ch < COUNTER_NUM; ch++) begin
      add_step($sformatf("reset_count%0d", ch), "rd", ch_reg(ch, REG_CH_COUNT), 0, 0);
    end
    add_step("reset_target0", "rd", ch_reg(0, REG_CH_TARGET), 0, '1);
    add_step("reset_int", "int", 0, 0, 0);
    add_step("reset_enable_out", "en", 0, 0, 0);
    // ch0 enabled and started, ch2 started while disabled
    add_step("enable_ch0", "wr", REG_ENABLE, 1, 0);
    add_step("enable_out_ch0", "en", 0, 0, 1);
    add_step("start_ch0", "wr", ch_reg(0, REG_CH_CMD), start_cmd, 0);
    add_step("start_ch2", "wr", ch_reg(2, REG_CH_CMD), start_cmd, 0);
    add_step("run_ch0", "idle", 0, 10, 0);
    add_step("stop_ch0", "wr", ch_reg(0, REG_CH_CMD), stop_cmd, 0);
    add_step("count0_running", "nz", ch_reg(0, REG_CH_COUNT), 0, 0);
    add_step("count0_held", "same", ch_reg(0, REG_CH_COUNT), 0, 0);
    add_step("count2_disabled", "rd", ch_reg(2, REG_CH_COUNT), 0, 0);
    // clear on a stopped channel
    add_step("clear_ch0", "wr", ch_reg(0, REG_CH_CMD), clear_cmd, 0);
    add_step("count0_cleared", "rd", ch_reg(0, REG_CH_COUNT), 0, 0);
    // two channels counting, then global stop and clear
    add_step("enable_all", "wr", REG_ENABLE, all_ch, 0);
    add_step("enable_out_all", "en", 0, 0, all_ch);
    add_step("restart_ch0", "wr", ch_reg(0, REG_CH_CMD), start_cmd, 0);
    add_step("run_two", "idle", 0, 5, 0);
    add_step("count0_before_gclr", "nz", ch_reg(0, REG_CH_COUNT), 0, 0);
    add_step("count2_before_gclr", "nz", ch_reg(2, REG_CH_COUNT), 0, 0);
    add_step("global_stop_clear", "wr", REG_GLOBAL_CMD, stop_cmd | clear_cmd, 0);
    for (int ch = 0; ch < COUNTER_NUM; ch++) begin
      add_step($sformatf("gclr_count%0d", ch), "rd", ch_reg(ch, REG_CH_COUNT), 0, 0);
    end
    // small target on ch1, unmasked
    add_step("write_target1", "wr", ch_reg(1, REG_CH_TARGET), tgt, 0);
    add_step("read_target1", "rd", ch_reg(1, REG_CH_TARGET), 0, tgt);
    add_step("unmask_ch1", "wr", REG_MASK_CLR, 2, 0);
    add_step("int_before_match", "int", 0, 0, 0);
    add_step("start_ch1", "wr", ch_reg(1, REG_CH_CMD), start_cmd, 0);
    add_step("run_to_match", "idle", 0, tgt + 4, 0);
    add_step("status_after_match", "rd", REG_INTR_STATUS, 0, 2);
    add_step("int_after_match", "int", 0, 0, 1);
    add_step("count1_bounded_a", "le", ch_reg(1, REG_CH_COUNT), 0, tgt);
    add_step("count1_bounded_b", "le", ch_reg(1, REG_CH_COUNT), 0, tgt);
    // masking hides the level, status stays
    add_step("mask_ch1", "wr", REG_MASK_SET, 2, 0);
    add_step("int_masked", "int", 0, 0, 0);
    add_step("status_masked", "rd", REG_INTR_STATUS, 0, 2);
    add_step("stop_ch1", "wr", ch_reg(1, REG_CH_CMD), stop_cmd, 0);
    add_step("w1c_status1", "wr", REG_INTR_STATUS, 2, 0);
    add_step("status_cleared", "rd", REG_INTR_STATUS, 0, 0);
    // software set on a channel with no match
    add_step("set_status3", "wr", REG_INTR_SET, 8, 0);
    add_step("status_set", "rd", REG_INTR_STATUS, 0, 8);
    add_step("unmask_ch3", "wr", REG_MASK_CLR, 8, 0);
    add_step("int_from_set", "int", 0, 0, 1);
    add_step("w1c_status3", "wr", REG_INTR_STATUS, 8, 0);
    add_step("int_after_w1c", "int", 0, 0, 0);
    add_step("status_empty", "rd", REG_INTR_STATUS, 0, 0);
    // ch1 masked again above, only ch3 left open
    add_step("mask_value", "rd", REG_INTR_MASK, 0, all_ch & ~DATA_W'(8));
    // large target again so ch1 reads nonzero below
    add_step("restore_target1", "wr", ch_reg(1, REG_CH_TARGET), '1, 0);
    add_step("global_start", "wr", REG_GLOBAL_CMD, start_cmd, 0);
    add_step("run_all", "idle", 0, 6, 0);
    for (int ch = 0; ch < COUNTER_NUM; ch++) begin
      add_step($sformatf("gstart_count%0d", ch), "nz", ch_reg(ch, REG_CH_COUNT), 0, 0);
    end
    add_step("int_quiet", "int", 0, 0, 0);
  endtask

  initial begin
    paddr   = '0;
    pwdata  = '0;
    pwrite  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    prst_n  = 1'b0;
    last_rd = '0;
    seed    = 32'h190f_07c7;
    // 4 to 11, short enough to wrap within one step
    tgt     = DATA_W'(4 + ($random(seed) & 7));
    build_table();
    limit   = step_name.size() * 40;
    repeat (10) @(negedge pclk);
    prst_n  = 1'b1;
    for (int i = 0; i < step_name.size(); i++) begin
      if (step_op[i] == "wr") begin
        apb_write(step_addr[i], step_data[i]);
      end else if (step_op[i] == "rd") begin
        apb_read(step_addr[i], rd_val);
        check(step_name[i], step_exp[i], rd_val);
      end else if (step_op[i] == "nz") begin
        apb_read(step_addr[i], rd_val);
        check(step_name[i], 1, DATA_W'(rd_val != 0));
      end else if (step_op[i] == "same") begin
        apb_read(step_addr[i], rd_val);
        check(step_name[i], last_rd, rd_val);
      end else if (step_op[i] == "le") begin
        apb_read(step_addr[i], rd_val);
        check(step_name[i], 1, DATA_W'(rd_val <= step_exp[i]));
      end else if (step_op[i] == "int") begin
        @(negedge pclk);
        check(step_name[i], step_exp[i], DATA_W'(intr));
      end else if (step_op[i] == "en") begin
        // enable pins follow the enable register
        @(negedge pclk);
        check(step_name[i], step_exp[i], DATA_W'(enable));
      end else begin
        repeat (step_data[i]) @(negedge pclk);
      end
      last_rd = rd_val;
    end
    $display("No errors");
    $finish;
  end

endmodule

// ==== sim.f ====
ctr_pkg.sv
ctr_chan_if.sv
ctr_apb_regs.sv
ctr_channel.sv
ctr_intr_ctrl.sv
ctr_top.sv
ctr_props.sv
tb_ctr_top.sv

// ==== Makefile ====
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -Wno-fatal -f sim.f \
		--top-module tb_ctr_top -Mdir $(OBJ_DIR) -o Vtb_ctr_top

run: compile
	./$(OBJ_DIR)/Vtb_ctr_top

clean:
	rm -rf $(OBJ_DIR)
